/* cpuPkg.sv */
package cpuPkg;

	// Datapath sizes
	localparam int dataW = 16;
	localparam int regIdxW = 2;
	localparam int numRegs = 1 << regIdxW;	// Four general registers
	localparam int opW = 3;
	localparam int aluOpW = 7;
	localparam int payloadW = 8;
	localparam int pcSelW = 2;

	// Opcodes, 010 and 100 unused and run as no-ops
	localparam logic [opW-1:0] opAlu = 3'b000;
	localparam logic [opW-1:0] opLdImm = 3'b001;
	localparam logic [opW-1:0] opLdInd = 3'b011;
	localparam logic [opW-1:0] opStInd = 3'b101;
	localparam logic [opW-1:0] opBrImm = 3'b110;
	localparam logic [opW-1:0] opBrInd = 3'b111;

	// ALU function in aluOp[2:0]
	localparam logic [2:0] aluAdd = 3'd0;
	localparam logic [2:0] aluSub = 3'd1;
	localparam logic [2:0] aluAnd = 3'd2;
	localparam logic [2:0] aluOr = 3'd3;
	localparam logic [2:0] aluXor = 3'd4;
	localparam logic [2:0] aluShl = 3'd5;
	localparam logic [2:0] aluShr = 3'd6;
	localparam logic [2:0] aluPass = 3'd7;
	localparam int aluCinBit = 3;	// Carry-in enable, bits above are reserved

	// Next PC source
	localparam logic [pcSelW-1:0] pcSeq = 2'b00;
	localparam logic [pcSelW-1:0] pcImm = 2'b01;
	localparam logic [pcSelW-1:0] pcReg = 2'b10;

	// Register-form layout: ALU op, loads, stores, indirect branch
	typedef struct packed {
		logic [opW-1:0] opcode;
		logic [regIdxW-1:0] rd;
		logic [regIdxW-1:0] rs1;
		logic [regIdxW-1:0] rs2;
		logic [aluOpW-1:0] aluOp;
	} aluLayout;

	// Immediate-form layout: load immediate and branches
	typedef struct packed {
		logic [opW-1:0] opcode;
		logic brFlagSel;	// 0 carry, 1 zero
		logic brFlag;	// Flag value that takes the branch
		logic [2:0] rsvd;
		logic [payloadW-1:0] payload;
	} immLayout;

	typedef union packed {
		aluLayout aluForm;
		immLayout immForm;
	} instrWord;

endpackage

/* ctrlIf.sv */
`timescale 1ns/1ps

interface ctrlIf;
	import cpuPkg::*;

	logic [pcSelW-1:0] nextPCSel;
	logic regDataInSource;	// Write back from memory
	logic immData;	// Write back from instrData
	logic regFileWE;
	logic memWE;
	logic dAddrSel;	// dAddr from rs1 instead of instrData
	logic flagWE;	// ALU ops only
	logic [dataW-1:0] instrData;
	logic [aluOpW-1:0] aluOp;
	logic [regIdxW-1:0] regDst;
	logic [regIdxW-1:0] regSrc1;
	logic [regIdxW-1:0] regSrc2;

	modport decoder (
		output nextPCSel, regDataInSource, immData, regFileWE, memWE, dAddrSel, flagWE,
		output instrData, aluOp, regDst, regSrc1, regSrc2
	);

	modport datapath (
		input nextPCSel, regDataInSource, immData, regFileWE, memWE, dAddrSel, flagWE,
		input instrData, aluOp, regDst, regSrc1, regSrc2
	);

endinterface

/* decoder.sv */
`timescale 1ns/1ps

module decoder (
	input cpuPkg::instrWord instruction,
	input logic cFlag,	// Branch condition inputs
	input logic zFlag,
	ctrlIf.decoder ctrl
);
	import cpuPkg::*;

	logic [opW-1:0] opcode;
	logic [dataW-1:0] payloadExt;
	logic condFlag;
	logic brTaken;

	assign opcode = instruction.immForm.opcode;

	// Register fields pulled out for every opcode
	assign ctrl.regDst = instruction.aluForm.rd;
	assign ctrl.regSrc1 = instruction.aluForm.rs1;
	assign ctrl.regSrc2 = instruction.aluForm.rs2;
	assign ctrl.aluOp = instruction.aluForm.aluOp;

	// Zero filled 8-bit payload
	assign payloadExt = {{(dataW-payloadW){1'b0}}, instruction.immForm.payload};

	// Carry or zero as brFlagSel picks
	assign condFlag = instruction.immForm.brFlagSel ? zFlag : cFlag;
	assign brTaken = (instruction.immForm.brFlag == condFlag);

	always_comb begin
		ctrl.nextPCSel = pcSeq;	// Fall through by default
		ctrl.regDataInSource = 1'b0;
		ctrl.immData = 1'b0;
		ctrl.regFileWE = 1'b0;
		ctrl.memWE = 1'b0;
		ctrl.dAddrSel = 1'b0;
		ctrl.flagWE = 1'b0;
		ctrl.instrData = '0;

		case (opcode)
			opAlu: begin
				ctrl.regFileWE = 1'b1;	// rd <= ALU result
				ctrl.flagWE = 1'b1;
			end

			opLdImm: begin
				ctrl.immData = 1'b1;	// rd <= payload
				ctrl.regFileWE = 1'b1;
				ctrl.instrData = payloadExt;
			end

			opLdInd: begin
				// Address from rs1 and data back from memory
				ctrl.dAddrSel = 1'b1;
				ctrl.regDataInSource = 1'b1;
				ctrl.regFileWE = 1'b1;
			end

			opStInd: begin
				ctrl.dAddrSel = 1'b1;	// mem[rs1] <= rs2
				ctrl.memWE = 1'b1;
			end

			opBrImm: begin
				if (brTaken) begin
					ctrl.nextPCSel = pcImm;
					ctrl.instrData = payloadExt;	// Target address
				end
			end

			opBrInd: begin
				if (brTaken) begin
					ctrl.nextPCSel = pcReg;	// Target in rs1
				end
			end

			default: begin
				// Unused opcodes write nothing
			end
		endcase
	end

endmodule

/* regFile.sv */
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic reset,
	ctrlIf.datapath ctrl,
	input logic [cpuPkg::dataW-1:0] aluResult,
	input logic [cpuPkg::dataW-1:0] dRdData,	// Load data
	output logic [cpuPkg::dataW-1:0] src1Data,
	output logic [cpuPkg::dataW-1:0] src2Data
);
	import cpuPkg::*;

	logic [dataW-1:0] regs [numRegs];
	logic [dataW-1:0] wrData;

	// Write-back source, memory first then immediate then ALU
	always_comb begin
		if (ctrl.regDataInSource)
			wrData = dRdData;
		else if (ctrl.immData)
			wrData = ctrl.instrData;
		else
			wrData = aluResult;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < numRegs; i++)
				regs[i] <= '0;
		end else if (ctrl.regFileWE) begin
			regs[ctrl.regDst] <= wrData;
		end
	end

	// Two combinational read ports
	assign src1Data = regs[ctrl.regSrc1];
	assign src2Data = regs[ctrl.regSrc2];

	// Only one non-ALU write-back source at a time
	aWbSrcOneHot: assert property (@(posedge clk) disable iff (reset)
		!(ctrl.regDataInSource && ctrl.immData))
		else $error("regFile: regDataInSource and immData high together");

endmodule

/* execUnit.sv */
`timescale 1ns/1ps

module execUnit (
	input logic clk,
	input logic reset,
	ctrlIf.datapath ctrl,
	input logic [cpuPkg::dataW-1:0] src1Data,
	input logic [cpuPkg::dataW-1:0] src2Data,
	output logic [cpuPkg::dataW-1:0] aluResult,
	output logic cFlag,
	output logic zFlag,
	output logic [cpuPkg::dataW-1:0] dAddr,
	output logic [cpuPkg::dataW-1:0] dWrData,
	output logic dWE
);
	import cpuPkg::*;

	logic [2:0] func;
	logic cin;
	logic [dataW:0] sum;	// One extra bit for carry or borrow
	logic carryNext;

	assign func = ctrl.aluOp[2:0];
	assign cin = ctrl.aluOp[aluCinBit] & cFlag;	// Carry-in only when enabled

	always_comb begin
		sum = '0;
		aluResult = '0;
		carryNext = 1'b0;	// Logic ops and pass clear carry
		case (func)
			aluAdd: begin
				sum = {1'b0, src1Data} + {1'b0, src2Data} + cin;
				aluResult = sum[dataW-1:0];
				carryNext = sum[dataW];
			end
			aluSub: begin
				sum = {1'b0, src1Data} - {1'b0, src2Data} + cin;
				aluResult = sum[dataW-1:0];
				carryNext = sum[dataW];	// Set on borrow
			end
			aluAnd: aluResult = src1Data & src2Data;
			aluOr: aluResult = src1Data | src2Data;
			aluXor: aluResult = src1Data ^ src2Data;
			aluShl: begin
				aluResult = {src1Data[dataW-2:0], 1'b0};
				carryNext = src1Data[dataW-1];	// Bit shifted out
			end
			aluShr: begin
				aluResult = {1'b0, src1Data[dataW-1:1]};
				carryNext = src1Data[0];
			end
			default: aluResult = src1Data;	// aluPass
		endcase
	end

	// Flags change on ALU ops only
	always_ff @(posedge clk) begin
		if (reset) begin
			cFlag <= 1'b0;
			zFlag <= 1'b0;
		end else if (ctrl.flagWE) begin
			cFlag <= carryNext;
			zFlag <= (aluResult == '0);
		end
	end

	assign dAddr = ctrl.dAddrSel ? src1Data : ctrl.instrData;	// Indirect address from rs1
	assign dWrData = src2Data;
	assign dWE = ctrl.memWE & ~reset;	// No stores while in reset

	// Reserved aluOp bits must be zero on real ALU ops
	aAluOpRsvd: assert property (@(posedge clk) disable iff (reset)
		ctrl.flagWE |-> (ctrl.aluOp[aluOpW-1:aluCinBit+1] == '0))
		else $error("execUnit: reserved aluOp bits set");

endmodule

/* pcUnit.sv */
`timescale 1ns/1ps

module pcUnit (
	input logic clk,
	input logic reset,
	ctrlIf.datapath ctrl,
	input logic [cpuPkg::dataW-1:0] src1Data,	// Indirect branch target
	output logic [cpuPkg::dataW-1:0] pc
);
	import cpuPkg::*;

	logic [dataW-1:0] pcNext;
	logic [dataW-1:0] pcInc;

	assign pcInc = pc + 1'b1;

	always_comb begin
		case (ctrl.nextPCSel)
			pcSeq: pcNext = pcInc;
			pcImm: pcNext = ctrl.instrData;	// Zero-extended payload
			pcReg: pcNext = src1Data;
			default: pcNext = pcInc;	// 11 never decoded
		endcase
	end

	// New pc every edge, nothing stalls
	always_ff @(posedge clk) begin
		if (reset)
			pc <= '0;
		else
			pc <= pcNext;
	end

	aPcSelLegal: assert property (@(posedge clk) disable iff (reset)
		ctrl.nextPCSel != 2'b11)
		else $error("pcUnit: illegal nextPCSel 11");

endmodule

/* cpuCore.sv */
`timescale 1ns/1ps

module cpuCore (
	input logic clk,
	input logic reset,
	output logic [cpuPkg::dataW-1:0] pc,	// Instruction fetch address
	input logic [cpuPkg::dataW-1:0] instruction,
	output logic [cpuPkg::dataW-1:0] dAddr,	// Data memory request
	output logic [cpuPkg::dataW-1:0] dWrData,
	output logic dWE,
	input logic [cpuPkg::dataW-1:0] dRdData
);
	import cpuPkg::*;

	logic cFlag;
	logic zFlag;
	logic [dataW-1:0] aluResult;
	logic [dataW-1:0] src1Data;
	logic [dataW-1:0] src2Data;

	ctrlIf ctrlBus ();	// Decoder control toward the datapath

	decoder u_decoder (
		.instruction(instruction),
		.cFlag(cFlag),
		.zFlag(zFlag),
		.ctrl(ctrlBus.decoder)
	);

	// Reads both operands alongside decode
	regFile u_regFile (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrlBus.datapath),
		.aluResult(aluResult),
		.dRdData(dRdData),
		.src1Data(src1Data),
		.src2Data(src2Data)
	);

	execUnit u_execUnit (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrlBus.datapath),
		.src1Data(src1Data),
		.src2Data(src2Data),
		.aluResult(aluResult),
		.cFlag(cFlag),
		.zFlag(zFlag),
		.dAddr(dAddr),
		.dWrData(dWrData),
		.dWE(dWE)
	);

	pcUnit u_pcUnit (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrlBus.datapath),
		.src1Data(src1Data),
		.pc(pc)
	);

endmodule

/* cpuTb.sv */
`timescale 1ns/1ps

module cpuTb;
	import cpuPkg::*;

	logic clk;
	logic reset;
	logic [dataW-1:0] pc;
	logic [dataW-1:0] instruction;
	logic [dataW-1:0] dAddr;
	logic [dataW-1:0] dWrData;
	logic dWE;
	logic [dataW-1:0] dRdData;

	logic [dataW-1:0] rom [1 << payloadW];	// Program ROM sized to the payload range
	string tagRom [1 << payloadW];	// Test name per ROM word
	logic [dataW-1:0] ram [1 << payloadW];
	logic [dataW-1:0] mRam [1 << payloadW];	// Model copy of the data RAM
	logic [dataW-1:0] mRegs [numRegs];
	logic [dataW-1:0] mPc;
	logic mC;
	logic mZ;
	instrWord mW;	// Word the model executes this cycle
	logic expWE;
	logic [dataW-1:0] expAddr;
	logic [dataW-1:0] expData;

	int seed = 32'h668108a6;
	int pcW;	// Assembler write pointer
	string asmTag;
	logic [dataW-1:0] secAddr [$];
	string secName [$];
	int mismatchCount = 0;
	int timeoutCount = 0;

	cpuCore u_cpuCore (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.instruction(instruction),
		.dAddr(dAddr),
		.dWrData(dWrData),
		.dWE(dWE),
		.dRdData(dRdData)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Memories answer combinationally with an idle word until pc leaves X
	assign instruction = $isunknown(pc) ? '0 : rom[pc[7:0]];
	assign dRdData = $isunknown(dAddr) ? '0 : ram[dAddr[7:0]];

	always @(posedge clk) begin
		if (dWE)
			ram[dAddr[7:0]] <= dWrData;	// Store taken at the edge
	end

	function automatic logic [dataW-1:0] fillPattern(input int a);
		return {a[7:0] ^ 8'h5a, ~a[7:0]};
	endfunction

	// Reference ALU returning {carry, result}
	function automatic logic [dataW:0] aluRef(input logic [2:0] f, input logic cinIn,
			input logic [dataW-1:0] a, input logic [dataW-1:0] b);
		int t;
		logic [dataW-1:0] r;
		logic c;
		r = '0;
		c = 1'b0;
		t = 0;
		case (f)
			aluAdd: begin
				t = int'(a) + int'(b) + int'(cinIn);
				r = t[15:0];
				c = (t > 65535);
			end
			aluSub: begin
				t = int'(a) - int'(b) + int'(cinIn);
				r = t[15:0];
				c = (t < 0);	// Borrow
			end
			aluAnd: r = a & b;
			aluOr: r = a | b;
			aluXor: r = a ^ b;
			aluShl: begin
				r = a << 1;
				c = a[15];
			end
			aluShr: begin
				r = a >> 1;
				c = a[0];
			end
			default: r = a;
		endcase
		return {c, r};
	endfunction

	// Reference model stepped from the same word each edge
	assign mW = rom[mPc[7:0]];
	assign expWE = (mW.aluForm.opcode == opStInd);
	assign expAddr = mRegs[mW.aluForm.rs1];
	assign expData = mRegs[mW.aluForm.rs2];

	always @(posedge clk) begin
		logic [dataW:0] aluOut;
		logic condOk;
		aluOut = aluRef(mW.aluForm.aluOp[2:0], mW.aluForm.aluOp[aluCinBit] & mC,
			mRegs[mW.aluForm.rs1], mRegs[mW.aluForm.rs2]);
		condOk = (mW.immForm.brFlag == (mW.immForm.brFlagSel ? mZ : mC));
		if (reset) begin
			mPc <= '0;
			mC <= 1'b0;
			mZ <= 1'b0;
			for (int i = 0; i < numRegs; i++)
				mRegs[i] <= '0;
		end else begin
			mPc <= mPc + 16'd1;
			case (mW.aluForm.opcode)
				opAlu: begin
					mRegs[mW.aluForm.rd] <= aluOut[15:0];
					mC <= aluOut[16];
					mZ <= (aluOut[15:0] == 16'h0);
				end
				opLdImm: mRegs[mW.aluForm.rd] <= {8'h00, mW.immForm.payload};
				opLdInd: mRegs[mW.aluForm.rd] <= mRam[mRegs[mW.aluForm.rs1][7:0]];
				opStInd: mRam[mRegs[mW.aluForm.rs1][7:0]] <= mRegs[mW.aluForm.rs2];
				opBrImm: if (condOk) mPc <= {8'h00, mW.immForm.payload};
				opBrInd: if (condOk) mPc <= mRegs[mW.aluForm.rs1];
				default: ;	// Unused opcodes
			endcase
		end
	end

	task automatic reportMismatch(input string test, input string what,
			input logic [dataW-1:0] exp, input logic [dataW-1:0] act);
		mismatchCount++;
		$display("mismatch %s %s: expected %h, actual %h", test, what, exp, act);
	endtask

	aResetDwe: assert property (@(posedge clk) reset |-> !dWE)
		else reportMismatch("reset", "dWE", 16'h0, {15'h0, $sampled(dWE)});
	aResetPc: assert property (@(posedge clk) reset |=> (pc == 16'h0))
		else reportMismatch("reset", "pc", 16'h0, $sampled(pc));
	aPcStep: assert property (@(posedge clk) disable iff (reset) pc == mPc)
		else reportMismatch(tagRom[$sampled(mPc[7:0])], "pc", $sampled(mPc), $sampled(pc));
	aStoreWe: assert property (@(posedge clk) disable iff (reset) dWE == expWE)
		else reportMismatch(tagRom[$sampled(mPc[7:0])], "dWE",
			{15'h0, $sampled(expWE)}, {15'h0, $sampled(dWE)});
	aStoreAddr: assert property (@(posedge clk) disable iff (reset) expWE |-> dAddr == expAddr)
		else reportMismatch(tagRom[$sampled(mPc[7:0])], "dAddr",
			$sampled(expAddr), $sampled(dAddr));
	aStoreData: assert property (@(posedge clk) disable iff (reset)
		expWE |-> dWrData == expData)
		else reportMismatch(tagRom[$sampled(mPc[7:0])], "dWrData",
			$sampled(expData), $sampled(dWrData));

	task automatic emitWord(input instrWord w);
		rom[pcW] = w;
		tagRom[pcW] = asmTag;
		pcW++;
	endtask

	task automatic markSection(input string name);
		secAddr.push_back(pcW[15:0]);
		secName.push_back(name);
		asmTag = name;
	endtask

	task automatic loadImm(input int rd, input int val);
		instrWord w;
		w = '0;
		w.aluForm.opcode = opLdImm;
		w.aluForm.rd = rd[1:0];
		w.immForm.payload = val[7:0];	// Shares no bits with rd
		emitWord(w);
	endtask

	// ALU op, indirect load or indirect store
	task automatic regOp(input logic [2:0] op, input int rd, input int rs1, input int rs2,
			input logic [aluOpW-1:0] aop);
		instrWord w;
		w.aluForm.opcode = op;
		w.aluForm.rd = rd[1:0];
		w.aluForm.rs1 = rs1[1:0];
		w.aluForm.rs2 = rs2[1:0];
		w.aluForm.aluOp = aop;
		emitWord(w);
	endtask

	task automatic branchWord(input logic [2:0] op, input int sel, input int flag,
			input int rs1, input int target);
		instrWord w;
		w = '0;
		w.aluForm.opcode = op;
		w.aluForm.rs1 = rs1[1:0];	// Sits in the reserved bits of the immediate form
		w.immForm.brFlagSel = sel[0];
		w.immForm.brFlag = flag[0];
		w.immForm.payload = target[7:0];
		emitWord(w);
	endtask

	// Branch that skips one slot where both outcomes rejoin
	task automatic branchOver(input logic [2:0] op, input int sel, input int flag, input int rs1);
		if (op == opBrInd)
			loadImm(rs1, pcW + 3);	// Target register
		branchWord(op, sel, flag, rs1, pcW + 2);
		loadImm(0, 8'hee);	// Slot runs only when not taken
	endtask

	task automatic buildProgram();
		logic [31:0] rnd;
		pcW = 0;
		for (int i = 0; i < (1 << payloadW); i++) begin
			rom[i] = '0;
			tagRom[i] = "unused";
			ram[i] = fillPattern(i);
			mRam[i] = fillPattern(i);
		end
		markSection("reset");
		regOp(opStInd, 0, 0, 0, 7'h0);	// Store seen while reset is still high
		markSection("ldImmStore");
		loadImm(1, 8'h21);
		loadImm(2, $random(seed));
		regOp(opStInd, 0, 1, 2, 7'h0);
		markSection("aluRandom");
		loadImm(3, 8'h40);	// Fixed store address
		for (int f = 0; f < 8; f++) begin
			for (int c = 0; c < 2; c++) begin
				loadImm(0, $random(seed));
				loadImm(1, $random(seed));
				// Chain on r2 with carry-in for wider operands
				regOp(opAlu, 2, (c == 1) ? 2 : 0, 1, {3'b000, c[0], f[2:0]});
				regOp(opStInd, 0, 3, 2, 7'h0);
				branchOver(opBrImm, 0, $random(seed), 0);	// Carry effect
				branchOver(opBrImm, 1, $random(seed), 0);	// Zero effect
			end
		end
		markSection("storeLoad");
		loadImm(0, 8'h80);
		regOp(opStInd, 0, 0, 2, 7'h0);
		regOp(opLdInd, 1, 0, 0, 7'h0);	// r1 <= mem[r0]
		loadImm(3, 8'h81);
		regOp(opStInd, 0, 3, 1, 7'h0);
		markSection("brImm");
		loadImm(1, 1);
		loadImm(3, 2);
		for (int k = 0; k < 2; k++) begin
			// 1 - 1 gives C0 Z1 and 1 - 2 borrows for C1 Z0
			regOp(opAlu, 2, 1, (k == 0) ? 1 : 3, {4'b0000, aluSub});
			for (int sel = 0; sel < 2; sel++)
				for (int flag = 0; flag < 2; flag++)
					branchOver(opBrImm, sel, flag, 0);
		end
		markSection("unusedOp");
		rnd = $random(seed);
		// rd field of each no-op names r2
		emitWord({3'b010, 2'd2, rnd[10:0]});
		emitWord({3'b100, 2'd2, rnd[26:16]});
		regOp(opStInd, 0, 3, 2, 7'h0);	// r2 untouched by the no-ops
		markSection("brInd");
		for (int sel = 0; sel < 2; sel++)
			for (int flag = 0; flag < 2; flag++)
				branchOver(opBrInd, sel, flag, 2);
		markSection("halt");
		branchWord(opBrImm, 0, 0, 0, pcW);	// Loops whatever the carry
		branchWord(opBrImm, 0, 1, 0, pcW - 1);
	endtask

	task automatic waitForPc(input logic [dataW-1:0] addr, input string what, input int limit,
			output bit ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < limit && !ok; n++) begin
			@(negedge clk);
			if (pc == addr)
				ok = 1'b1;
		end
		if (!ok) begin
			timeoutCount++;
			$display("timeout: pc did not reach section %s at %h within %0d cycles",
				what, addr, limit);
		end
	endtask

	initial begin
		bit reached;
		reset = 1'b1;
		buildProgram();
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		reached = 1'b1;
		for (int s = 0; s < secAddr.size() && reached; s++)
			waitForPc(secAddr[s], secName[s], 300, reached);
		if (reached)
			repeat (4) @(negedge clk);	// Let the halt loop spin
		$display("Closing: %0d mismatches, %0d timeouts", mismatchCount, timeoutCount);
		if (mismatchCount == 0 && timeoutCount == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* cpuCore.f */
cpuPkg.sv
ctrlIf.sv
decoder.sv
regFile.sv
execUnit.sv
pcUnit.sv
cpuCore.sv
cpuTb.sv
